/* all.f */
+incdir+include
src/soc_pkg.sv
src/soc_split.sv
src/soc_int_mem.sv
src/soc_timer.sv
src/soc_top.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/tb_soc.sv

/* Makefile */
# Verilator build and run of the SoC testbench

VERILATOR ?= verilator
TOP       ?= tb_soc
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) include/soc_config.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "All tests passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_soc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module tb_soc;

   localparam int P_IDLE = 0;
   localparam int P_IBUS = 1;
   localparam int P_DBUS = 2;
   localparam int P_BOTH = 3;
   localparam int P_BOOT = 4;
   localparam int P_IRQ  = 5;
   localparam int MAX_ENT = 160;
   localparam logic [15:0] CTRL_ADDR = 16'h4000;
   localparam logic [15:0] TMR_COUNT_A = 16'h8000;
   localparam logic [15:0] TMR_CTRL_A = 16'h8004;
   localparam logic [15:0] TMR_CMP_A = 16'h8008;
   localparam logic [15:0] TMR_STAT_A = 16'h800C;
   localparam logic [31:0] CMP_VAL = 32'd24;

   wire                    clk;
   wire                    arst_n;
   logic                   ibus_valid;
   logic [`SOC_ADDR_W-1:0] ibus_addr;
   wire                    ibus_ready;
   wire  [`SOC_DATA_W-1:0] ibus_rdata;
   wire                    ibus_rvalid;
   logic                   dbus_valid;
   logic [`SOC_ADDR_W-1:0] dbus_addr;
   logic [`SOC_DATA_W-1:0] dbus_wdata;
   logic [`SOC_STRB_W-1:0] dbus_wstrb;
   wire                    dbus_ready;
   wire  [`SOC_DATA_W-1:0] dbus_rdata;
   wire                    dbus_rvalid;
   wire                    rom_r_valid;
   wire  [`SOC_ROM_AW-1:0] rom_r_addr;
   logic [`SOC_DATA_W-1:0] rom_rdata;
   wire                    boot;
   wire                    cpu_reset;
   wire                    irq;

   // expectations that travel with each request
   logic [31:0] exp_i_data;
   logic [31:0] exp_d_data;
   logic [1:0]  exp_mode;
   logic [31:0] exp_tag;
   logic        exp_stall;
   logic        exp_rom;
   logic [1:0]  flag_sel;
   logic        flag_exp;
   int          pass_cnt;
   int          fail_cnt;
   int          pending;
   int          rst_pulses;

   // stimulus table
   int          tbl_port [MAX_ENT];
   logic [15:0] tbl_addr [MAX_ENT];
   logic [31:0] tbl_wdata [MAX_ENT];
   logic [3:0]  tbl_wstrb [MAX_ENT];
   logic [31:0] tbl_exp [MAX_ENT];
   bit          tbl_stall [MAX_ENT];
   int          tbl_mode [MAX_ENT];
   int          n_ent = 0;
   int          errors = 0;
   int unsigned cycles = 0;
   int unsigned limit = 0;
   bit          in_boot = 1'b1;
   logic [31:0] sram_model [8];

   tb_clk_gen clk_gen (
      .clk_o    (clk),
      .arst_n_o (arst_n)
   );

   soc_top DUT (
      .clk_i (clk), .arst_n_i (arst_n),
      .ibus_valid_i (ibus_valid), .ibus_addr_i (ibus_addr), .ibus_ready_o (ibus_ready),
      .ibus_rdata_o (ibus_rdata), .ibus_rvalid_o (ibus_rvalid),
      .dbus_valid_i (dbus_valid), .dbus_addr_i (dbus_addr), .dbus_wdata_i (dbus_wdata),
      .dbus_wstrb_i (dbus_wstrb), .dbus_ready_o (dbus_ready), .dbus_rdata_o (dbus_rdata),
      .dbus_rvalid_o (dbus_rvalid),
      .rom_r_valid_o (rom_r_valid), .rom_r_addr_o (rom_r_addr), .rom_r_rdata_i (rom_rdata),
      .boot_o (boot), .cpu_reset_o (cpu_reset), .irq_o (irq)
   );

   tb_checker chk (
      .clk_i (clk), .arst_n_i (arst_n),
      .ibus_valid_i (ibus_valid), .ibus_ready_i (ibus_ready), .ibus_rvalid_i (ibus_rvalid),
      .ibus_rdata_i (ibus_rdata), .dbus_valid_i (dbus_valid), .dbus_wstrb_i (dbus_wstrb),
      .dbus_ready_i (dbus_ready), .dbus_rvalid_i (dbus_rvalid), .dbus_rdata_i (dbus_rdata),
      .rom_r_valid_i (rom_r_valid), .boot_i (boot), .irq_i (irq), .cpu_reset_i (cpu_reset),
      .exp_i_data_i (exp_i_data), .exp_d_data_i (exp_d_data), .exp_mode_i (exp_mode),
      .exp_tag_i (exp_tag), .exp_stall_i (exp_stall), .exp_rom_i (exp_rom),
      .flag_sel_i (flag_sel), .flag_exp_i (flag_exp), .pass_cnt_o (pass_cnt),
      .fail_cnt_o (fail_cnt), .pending_o (pending), .rst_pulses_o (rst_pulses)
   );

   // boot rom contents follow a fixed rule of the word address
   function automatic logic [31:0] rom_word(input logic [`SOC_ROM_AW-1:0] a);
      return ({24'd0, a} * 32'h01010101) ^ 32'h0000B007;
   endfunction

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) rom_rdata <= '0;
      else if (rom_r_valid) rom_rdata <= rom_word(rom_r_addr);
   end

   function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] nw,
                                         input logic [3:0] strb);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) res[b*8 +: 8] = nw[b*8 +: 8];
      end
      return res;
   endfunction

   task automatic add_entry(input int port, input logic [15:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, input logic [31:0] exp, input bit stall,
                            input int mode);
      tbl_port[n_ent]  = port;
      tbl_addr[n_ent]  = addr;
      tbl_wdata[n_ent] = wdata;
      tbl_wstrb[n_ent] = wstrb;
      tbl_exp[n_ent]   = exp;
      tbl_stall[n_ent] = stall;
      tbl_mode[n_ent]  = mode;
      n_ent++;
   endtask

   task automatic add_idles(input int n);
      for (int i = 0; i < n; i++) add_entry(P_IDLE, '0, '0, '0, '0, 1'b0, 0);
   endtask

   task automatic add_write(input logic [15:0] addr, input logic [31:0] d, input logic [3:0] s);
      add_entry(P_DBUS, addr, d, s, '0, 1'b0, 0);
   endtask

   task automatic add_read(input logic [15:0] addr, input logic [31:0] exp, input int mode);
      add_entry(P_DBUS, addr, '0, '0, exp, 1'b0, mode);
   endtask

   task automatic build_table();
      logic [31:0] d;
      // boot fetches from the rom
      add_entry(P_BOOT, '0, '0, '0, 32'd1, 1'b0, 0);
      for (int w = 0; w < 4; w++) add_entry(P_IBUS, 16'(w * 4), '0, '0, rom_word(8'(w)), 1'b0, 0);
      // sram full and partial writes then read back
      for (int w = 0; w < 8; w++) begin
         sram_model[w] = $urandom;
         add_write(16'(w * 4), sram_model[w], 4'hF);
      end
      d = $urandom;
      sram_model[2] = merge(sram_model[2], d, 4'b0101);
      add_write(16'h0008, d, 4'b0101);
      d = $urandom;
      sram_model[5] = merge(sram_model[5], d, 4'b1000);
      add_write(16'h0014, d, 4'b1000);
      for (int w = 0; w < 8; w++) add_read(16'(w * 4), sram_model[w], 0);
      // timer counting, match, interrupt and clear
      add_write(TMR_CMP_A, CMP_VAL, 4'hF);
      add_write(TMR_CTRL_A, 32'd1, 4'hF);
      add_read(TMR_COUNT_A, '0, 1);
      add_idles(3);
      add_read(TMR_COUNT_A, 32'd4, 2);
      add_idles(28);
      add_entry(P_IRQ, '0, '0, '0, 32'd1, 1'b0, 0);
      add_read(TMR_STAT_A, 32'd1, 0);
      add_write(TMR_STAT_A, 32'd1, 4'hF);
      add_entry(P_IRQ, '0, '0, '0, 32'd0, 1'b0, 0);
      add_read(TMR_STAT_A, 32'd0, 0);
      add_write(TMR_CTRL_A, 32'd0, 4'hF);
      add_read(TMR_COUNT_A, '0, 1);
      add_idles(1);
      add_read(TMR_COUNT_A, 32'd0, 2);
      // leaving boot pulses cpu reset which clears the stopped counter
      add_write(CTRL_ADDR, 32'd0, 4'hF);
      add_entry(P_BOOT, '0, '0, '0, 32'd0, 1'b0, 0);
      add_idles(5);
      add_read(CTRL_ADDR, 32'd0, 0);
      add_read(TMR_COUNT_A, 32'd0, 0);
      for (int w = 0; w < 8; w++) add_entry(P_IBUS, 16'(w * 4), '0, '0, sram_model[w], 1'b0, 0);
      // fetch and data read collide
      add_entry(P_BOTH, 16'h000C, '0, '0, sram_model[3], 1'b1, 0);
      add_entry(P_BOTH, 16'h0018, '0, '0, sram_model[6], 1'b1, 0);
      // pipelined reads alternating sram and timer
      for (int w = 0; w < 4; w++) begin
         add_read(16'(w * 4), sram_model[w], 0);
         add_read(TMR_CMP_A, CMP_VAL, 0);
      end
   endtask

   task automatic drive_entry(input int e);
      ibus_valid = 1'b0;
      dbus_valid = 1'b0;
      dbus_wstrb = '0;
      flag_sel   = 2'd0;
      exp_tag    = 32'(e);
      exp_mode   = 2'(tbl_mode[e]);
      exp_stall  = tbl_stall[e];
      exp_rom    = in_boot;
      flag_exp   = tbl_exp[e][0];
      if (tbl_port[e] == P_IBUS || tbl_port[e] == P_BOTH) begin
         ibus_valid = 1'b1;
         ibus_addr  = tbl_addr[e];
         exp_i_data = tbl_exp[e];
      end
      if (tbl_port[e] == P_DBUS || tbl_port[e] == P_BOTH) begin
         dbus_valid = 1'b1;
         dbus_addr  = tbl_addr[e];
         dbus_wdata = tbl_wdata[e];
         dbus_wstrb = tbl_wstrb[e];
         exp_d_data = tbl_exp[e];
      end
      // writing 0 to the control word ends the boot phase for later fetches
      if (dbus_valid && dbus_wstrb[0] && !tbl_addr[e][`SOC_SEL_BIT] &&
          tbl_addr[e][`SOC_CTRL_BIT] && !tbl_wdata[e][0]) begin
         in_boot = 1'b0;
      end
      if (tbl_port[e] == P_BOOT) flag_sel = 2'd1;
      if (tbl_port[e] == P_IRQ) flag_sel = 2'd2;
   endtask

   // run limit scales with the table
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit != 0 && cycles >= limit) begin
         $display("timeout after %0d cycles", cycles);
         $display("Some tests failed");
         $finish;
      end
   end

   initial begin
      int hold;
      int waits;
      void'($urandom(32'h51de));
      ibus_valid = 1'b0;
      ibus_addr  = '0;
      dbus_valid = 1'b0;
      dbus_addr  = '0;
      dbus_wdata = '0;
      dbus_wstrb = '0;
      exp_i_data = '0;
      exp_d_data = '0;
      exp_mode   = '0;
      exp_tag    = '0;
      exp_stall  = 1'b0;
      exp_rom    = 1'b0;
      flag_sel   = 2'd0;
      flag_exp   = 1'b0;
      build_table();
      limit = n_ent * 8 + 100;
      @(posedge arst_n);
      for (int e = 0; e < n_ent; e++) begin
         @(posedge clk);
         #1;
         drive_entry(e);
         @(negedge clk);
         hold = 0;
         // a data request stays up until the memory takes it
         while (dbus_valid && !dbus_ready) begin
            hold++;
            if (hold > 4) begin
               errors++;
               $display("data request of test %0d was never accepted", e);
               break;
            end
            @(posedge clk);
            #1;
            ibus_valid = 1'b0;
            exp_stall  = 1'b0;
            @(negedge clk);
         end
      end
      @(posedge clk);
      #1;
      ibus_valid = 1'b0;
      dbus_valid = 1'b0;
      dbus_wstrb = '0;
      flag_sel   = 2'd0;
      waits = 0;
      while (pending != 0 && waits < 4) begin
         @(negedge clk);
         waits++;
      end
      if (pending != 0) begin
         errors++;
         $display("some read responses never arrived");
      end
      if (rst_pulses != 1) begin
         errors++;
         $display("saw %0d cpu reset pulses instead of one", rst_pulses);
      end
      $display("%0d checks passed, %0d failed", pass_cnt, fail_cnt + errors);
      if (fail_cnt + errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* dv/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module tb_checker (
   input  wire                    clk_i,
   input  wire                    arst_n_i,
   input  wire                    ibus_valid_i,
   input  wire                    ibus_ready_i,
   input  wire                    ibus_rvalid_i,
   input  wire [`SOC_DATA_W-1:0]  ibus_rdata_i,
   input  wire                    dbus_valid_i,
   input  wire [`SOC_STRB_W-1:0]  dbus_wstrb_i,
   input  wire                    dbus_ready_i,
   input  wire                    dbus_rvalid_i,
   input  wire [`SOC_DATA_W-1:0]  dbus_rdata_i,
   input  wire                    rom_r_valid_i,
   input  wire                    boot_i,
   input  wire                    irq_i,
   input  wire                    cpu_reset_i,
   input  wire [`SOC_DATA_W-1:0]  exp_i_data_i,
   input  wire [`SOC_DATA_W-1:0]  exp_d_data_i,
   input  wire [1:0]              exp_mode_i,
   input  wire [31:0]             exp_tag_i,
   input  wire                    exp_stall_i,
   input  wire                    exp_rom_i,
   input  wire [1:0]              flag_sel_i,
   input  wire                    flag_exp_i,
   output int                     pass_cnt_o,
   output int                     fail_cnt_o,
   output int                     pending_o,
   output int                     rst_pulses_o
);

   // outstanding reads with the oldest first
   logic [`SOC_DATA_W-1:0] iq_data [$];
   int                     iq_tag [$];
   int                     iq_due [$];
   logic [`SOC_DATA_W-1:0] dq_data [$];
   logic [1:0]             dq_mode [$];
   int                     dq_tag [$];
   int                     dq_due [$];
   int                     pass_cnt = 0;
   int                     fail_cnt = 0;
   int                     pending = 0;
   int                     rst_pulses = 0;
   int                     rst_run = 0;
   int                     cyc = 0;
   logic [`SOC_DATA_W-1:0] last_d = '0;

   assign pass_cnt_o   = pass_cnt;
   assign fail_cnt_o   = fail_cnt;
   assign pending_o    = pending;
   assign rst_pulses_o = rst_pulses;

   task automatic score(input bit ok, input string what, input logic [31:0] got,
                        input logic [31:0] exp);
      if (ok) begin
         pass_cnt++;
         $display("%s passed, value %h", what, got);
      end else begin
         fail_cnt++;
         $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic note_failure(input string msg);
      fail_cnt++;
      $display("%s", msg);
   endtask

   always @(negedge clk_i) begin
      logic [31:0] exp;
      logic [1:0]  mode;
      int          tag;
      if (arst_n_i) begin
         cyc++;

         // fetch responses
         if (ibus_rvalid_i) begin
            if (iq_data.size() == 0) begin
               note_failure($sformatf("ibus rvalid at %0t with no fetch outstanding", $time));
            end else begin
               exp = iq_data.pop_front();
               tag = iq_tag.pop_front();
               void'(iq_due.pop_front());
               score(ibus_rdata_i === exp, $sformatf("test %0d fetch", tag), ibus_rdata_i, exp);
            end
         end else if (iq_due.size() != 0 && iq_due[0] <= cyc) begin
            void'(iq_data.pop_front());
            void'(iq_due.pop_front());
            tag = iq_tag.pop_front();
            note_failure($sformatf("test %0d: fetch got no rvalid", tag));
         end

         // mode 1 captures a data response and mode 2 is relative to the last one
         if (dbus_rvalid_i) begin
            if (dq_data.size() == 0) begin
               note_failure($sformatf("dbus rvalid at %0t with no read outstanding", $time));
            end else begin
               exp  = dq_data.pop_front();
               mode = dq_mode.pop_front();
               tag  = dq_tag.pop_front();
               void'(dq_due.pop_front());
               if (mode == 2'd1) begin
                  pass_cnt++;
                  $display("test %0d passed, captured %h", tag, dbus_rdata_i);
               end else begin
                  if (mode == 2'd2) exp = last_d + exp;
                  score(dbus_rdata_i === exp, $sformatf("test %0d data read", tag),
                        dbus_rdata_i, exp);
               end
               last_d = dbus_rdata_i;
            end
         end else if (dq_due.size() != 0 && dq_due[0] <= cyc) begin
            void'(dq_data.pop_front());
            void'(dq_mode.pop_front());
            void'(dq_due.pop_front());
            tag = dq_tag.pop_front();
            note_failure($sformatf("test %0d: data read got no rvalid", tag));
         end

         // requests accepted in this cycle
         if (ibus_valid_i && ibus_ready_i) begin
            iq_data.push_back(exp_i_data_i);
            iq_tag.push_back(int'(exp_tag_i));
            iq_due.push_back(cyc + 1);
         end
         if (dbus_valid_i && dbus_ready_i && dbus_wstrb_i == '0) begin
            dq_data.push_back(exp_d_data_i);
            dq_mode.push_back(exp_mode_i);
            dq_tag.push_back(int'(exp_tag_i));
            dq_due.push_back(cyc + 1);
         end

         if (dbus_valid_i) begin
            if (exp_stall_i && dbus_ready_i) begin
               note_failure($sformatf("test %0d: data request accepted during a fetch",
                                      exp_tag_i));
            end else if (exp_stall_i) begin
               pass_cnt++;
               $display("test %0d passed, data request stalled", exp_tag_i);
            end else if (!dbus_ready_i) begin
               note_failure($sformatf("test %0d: data request stalled unexpectedly",
                                      exp_tag_i));
            end
         end

         // fetches leave through the rom port only while booting
         if (ibus_valid_i) begin
            score(rom_r_valid_i === exp_rom_i, $sformatf("test %0d rom_r_valid_o", exp_tag_i),
                  32'(rom_r_valid_i), 32'(exp_rom_i));
         end else if (rom_r_valid_i) begin
            note_failure($sformatf("rom_r_valid_o high at %0t without a fetch", $time));
         end

         case (flag_sel_i)
            2'd1: score(boot_i === flag_exp_i, $sformatf("test %0d boot_o", exp_tag_i),
                        32'(boot_i), 32'(flag_exp_i));
            2'd2: score(irq_i === flag_exp_i, $sformatf("test %0d irq_o", exp_tag_i),
                        32'(irq_i), 32'(flag_exp_i));
            default: ;
         endcase

         // measure the cpu reset pulse when it ends
         if (cpu_reset_i) begin
            rst_run++;
         end else if (rst_run != 0) begin
            rst_pulses++;
            score(rst_run == `SOC_RST_CYCLES, "cpu reset pulse length", 32'(rst_run),
                  32'(`SOC_RST_CYCLES));
            rst_run = 0;
         end

         pending = iq_data.size() + dq_data.size();
      end
   end

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic clk_o,
   output logic arst_n_o
);

   // 40 ns period
   initial begin
      clk_o = 1'b0;
      forever #20 clk_o = ~clk_o;
   end

   // reset held for three rising edges
   initial begin
      arst_n_o = 1'b0;
      repeat (3) @(posedge clk_o);
      #1;
      arst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

/* src/soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module soc_top (
   input  wire                    clk_i,
   input  wire                    arst_n_i,

   // instruction bus
   input  wire                    ibus_valid_i,
   input  wire [`SOC_ADDR_W-1:0]  ibus_addr_i,
   output wire                    ibus_ready_o,
   output wire [`SOC_DATA_W-1:0]  ibus_rdata_o,
   output wire                    ibus_rvalid_o,

   // data bus
   input  wire                    dbus_valid_i,
   input  wire [`SOC_ADDR_W-1:0]  dbus_addr_i,
   input  wire [`SOC_DATA_W-1:0]  dbus_wdata_i,
   input  wire [`SOC_STRB_W-1:0]  dbus_wstrb_i,
   output wire                    dbus_ready_o,
   output wire [`SOC_DATA_W-1:0]  dbus_rdata_o,
   output wire                    dbus_rvalid_o,

   // boot rom
   output wire                    rom_r_valid_o,
   output wire [`SOC_ROM_AW-1:0]  rom_r_addr_o,
   input  wire [`SOC_DATA_W-1:0]  rom_r_rdata_i,

   output wire                    boot_o,
   output wire                    cpu_reset_o,
   output wire                    irq_o
);

   // slave buses behind the split
   wire [1:0]                  s_valid;
   wire [1:0][`SOC_ADDR_W-1:0] s_addr;
   wire [1:0][`SOC_DATA_W-1:0] s_wdata;
   wire [1:0][`SOC_STRB_W-1:0] s_wstrb;
   wire [1:0]                  s_ready;
   wire [1:0][`SOC_DATA_W-1:0] s_rdata;
   wire [1:0]                  s_rvalid;

   soc_split pbus_split (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .m_valid_i  (dbus_valid_i),
      .m_addr_i   (dbus_addr_i),
      .m_wdata_i  (dbus_wdata_i),
      .m_wstrb_i  (dbus_wstrb_i),
      .m_ready_o  (dbus_ready_o),
      .m_rdata_o  (dbus_rdata_o),
      .m_rvalid_o (dbus_rvalid_o),
      .s_valid_o  (s_valid),
      .s_addr_o   (s_addr),
      .s_wdata_o  (s_wdata),
      .s_wstrb_o  (s_wstrb),
      .s_ready_i  (s_ready),
      .s_rdata_i  (s_rdata),
      .s_rvalid_i (s_rvalid)
   );

   // no external memory, so fetches go straight in
   soc_int_mem int_mem0 (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .i_valid_i     (ibus_valid_i),
      .i_addr_i      (ibus_addr_i),
      .i_ready_o     (ibus_ready_o),
      .i_rdata_o     (ibus_rdata_o),
      .i_rvalid_o    (ibus_rvalid_o),
      .d_valid_i     (s_valid[0]),
      .d_addr_i      (s_addr[0]),
      .d_wdata_i     (s_wdata[0]),
      .d_wstrb_i     (s_wstrb[0]),
      .d_ready_o     (s_ready[0]),
      .d_rdata_o     (s_rdata[0]),
      .d_rvalid_o    (s_rvalid[0]),
      .rom_r_valid_o (rom_r_valid_o),
      .rom_r_addr_o  (rom_r_addr_o),
      .rom_r_rdata_i (rom_r_rdata_i),
      .boot_o        (boot_o),
      .cpu_reset_o   (cpu_reset_o)
   );

   soc_timer timer0 (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .cpu_reset_i (cpu_reset_o),
      .valid_i     (s_valid[1]),
      .addr_i      (s_addr[1]),
      .wdata_i     (s_wdata[1]),
      .wstrb_i     (s_wstrb[1]),
      .ready_o     (s_ready[1]),
      .rdata_o     (s_rdata[1]),
      .rvalid_o    (s_rvalid[1]),
      .irq_o       (irq_o)
   );

endmodule

`default_nettype wire

/* src/soc_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module soc_timer
   import soc_pkg::*;
(
   input  wire                     clk_i,
   input  wire                     arst_n_i,
   input  wire                     cpu_reset_i,
   input  wire                     valid_i,
   input  wire  [`SOC_ADDR_W-1:0]  addr_i,
   input  wire  [`SOC_DATA_W-1:0]  wdata_i,
   input  wire  [`SOC_STRB_W-1:0]  wstrb_i,
   output logic                    ready_o,
   output logic [`SOC_DATA_W-1:0]  rdata_o,
   output logic                    rvalid_o,
   output logic                    irq_o
);

   soc_addr_t              addr;
   timer_reg_e             reg_idx;
   logic                   wr;
   logic                   match_set;
   logic [`SOC_DATA_W-1:0] rd_word;
   logic [`SOC_DATA_W-1:0] count_q;
   logic [`SOC_DATA_W-1:0] cmp_q;
   logic                   en_q;
   logic                   match_q;
   logic                   rvalid_q;
   logic [`SOC_DATA_W-1:0] rdata_q;

   assign addr.raw  = addr_i;
   assign reg_idx   = addr.periph.reg_idx;
   assign ready_o   = 1'b1;
   assign wr        = valid_i && (wstrb_i != '0);
   assign match_set = en_q && (count_q == cmp_q);

   always_comb begin
      case (reg_idx)
         TMR_COUNT: rd_word = count_q;
         TMR_CTRL:  rd_word = {{(`SOC_DATA_W-1){1'b0}}, en_q};
         TMR_CMP:   rd_word = cmp_q;
         default:   rd_word = {{(`SOC_DATA_W-1){1'b0}}, match_q};
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count_q  <= '0;
         cmp_q    <= '0;
         en_q     <= 1'b0;
         match_q  <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         // cpu reset restarts the count
         if (cpu_reset_i) count_q <= '0;
         else if (en_q) count_q <= count_q + 1'b1;

         if (wr && reg_idx == TMR_CTRL && wstrb_i[0]) en_q <= wdata_i[0];
         if (wr && reg_idx == TMR_CMP) begin
            for (int b = 0; b < `SOC_STRB_W; b++) begin
               if (wstrb_i[b]) cmp_q[b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
         end

         // sticky, a new match beats a clear
         if (match_set) match_q <= 1'b1;
         else if (wr && reg_idx == TMR_STATUS && wstrb_i[0] && wdata_i[0]) match_q <= 1'b0;

         rvalid_q <= valid_i && !wr;
      end
   end

   always_ff @(posedge clk_i) begin
      if (valid_i && !wr) rdata_q <= rd_word;
   end

   assign rvalid_o = rvalid_q;
   assign rdata_o  = rdata_q;
   assign irq_o    = match_q && en_q;

   a_match_en : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      $rose(match_q) |-> $past(en_q)
   );

endmodule

`default_nettype wire

/* src/soc_int_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module soc_int_mem
   import soc_pkg::*;
(
   input  wire                          clk_i,
   input  wire                          arst_n_i,

   // instruction bus
   input  wire                          i_valid_i,
   input  wire  [`SOC_ADDR_W-1:0]       i_addr_i,
   output logic                         i_ready_o,
   output logic [`SOC_DATA_W-1:0]       i_rdata_o,
   output logic                         i_rvalid_o,

   // data bus
   input  wire                          d_valid_i,
   input  wire  [`SOC_ADDR_W-1:0]       d_addr_i,
   input  wire  [`SOC_DATA_W-1:0]       d_wdata_i,
   input  wire  [`SOC_STRB_W-1:0]       d_wstrb_i,
   output logic                         d_ready_o,
   output logic [`SOC_DATA_W-1:0]       d_rdata_o,
   output logic                         d_rvalid_o,

   // boot rom read port
   output logic                         rom_r_valid_o,
   output logic [`SOC_ROM_AW-1:0]       rom_r_addr_o,
   input  wire  [`SOC_DATA_W-1:0]       rom_r_rdata_i,

   output logic                         boot_o,
   output logic                         cpu_reset_o
);

   localparam int RstCntW = $clog2(`SOC_RST_CYCLES + 1);

   logic [`SOC_DATA_W-1:0]  sram [2**`SOC_SRAM_AW];
   soc_addr_t               i_addr;
   soc_addr_t               d_addr;
   logic                    i_sram;
   logic                    d_acc;
   logic                    d_wr;
   logic                    d_ctrl;
   logic                    sram_we;
   logic                    sram_re;
   logic [`SOC_SRAM_AW-1:0] sram_addr;
   logic [`SOC_DATA_W-1:0]  sram_rdata_q;
   logic                    boot_q;
   logic                    boot_clr;
   logic [RstCntW-1:0]      rst_cnt_q;
   logic                    i_rvalid_q;
   logic                    i_rom_q;
   logic                    d_rvalid_q;
   logic                    d_ctrl_q;

   assign i_addr.raw = i_addr_i;
   assign d_addr.raw = d_addr_i;

   // instruction side always wins, data waits a cycle
   assign i_ready_o = 1'b1;
   assign d_ready_o = !i_valid_i;

   assign i_sram = i_valid_i && !boot_q;
   assign d_acc  = d_valid_i && d_ready_o;
   assign d_wr   = |d_wstrb_i;
   assign d_ctrl = d_addr.mem.ctrl;

   // fetches during boot go out to the rom
   assign rom_r_valid_o = i_valid_i && boot_q;
   assign rom_r_addr_o  = i_addr.mem.word[`SOC_ROM_AW-1:0];

   assign sram_addr = i_sram ? i_addr.mem.word : d_addr.mem.word;
   assign sram_we   = d_acc && d_wr && !d_ctrl;
   assign sram_re   = i_sram || (d_acc && !d_wr && !d_ctrl);

   always_ff @(posedge clk_i) begin
      if (sram_we) begin
         for (int b = 0; b < `SOC_STRB_W; b++) begin
            if (d_wstrb_i[b]) sram[sram_addr][b*8 +: 8] <= d_wdata_i[b*8 +: 8];
         end
      end
      if (sram_re) begin
         sram_rdata_q <= sram[sram_addr];
      end
   end

   // writing 0 to bit 0 of the control word leaves boot
   assign boot_clr = d_acc && d_wr && d_ctrl && d_wstrb_i[0] && !d_wdata_i[0];

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         boot_q     <= 1'b1;
         rst_cnt_q  <= '0;
         i_rvalid_q <= 1'b0;
         i_rom_q    <= 1'b0;
         d_rvalid_q <= 1'b0;
         d_ctrl_q   <= 1'b0;
      end else begin
         if (boot_clr) begin
            boot_q    <= 1'b0;
            rst_cnt_q <= RstCntW'(`SOC_RST_CYCLES);
         end else if (rst_cnt_q != '0) begin
            rst_cnt_q <= rst_cnt_q - 1'b1;
         end
         i_rvalid_q <= i_valid_i;
         i_rom_q    <= boot_q;
         d_rvalid_q <= d_acc && !d_wr;
         d_ctrl_q   <= d_ctrl;
      end
   end

   assign i_rvalid_o = i_rvalid_q;
   assign i_rdata_o  = i_rom_q ? rom_r_rdata_i : sram_rdata_q;
   assign d_rvalid_o = d_rvalid_q;
   assign d_rdata_o  = d_ctrl_q ? {{(`SOC_DATA_W-1){1'b0}}, boot_q} : sram_rdata_q;

   assign boot_o      = boot_q;
   assign cpu_reset_o = (rst_cnt_q != '0);

   a_i_resp : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      i_rvalid_o |-> $past(i_valid_i && i_ready_o)
   );

   // data must never slip in under a fetch
   a_grant : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      (i_valid_i && i_ready_o) |-> !d_ready_o
   );

endmodule

`default_nettype wire

/* src/soc_split.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module soc_split
   import soc_pkg::*;
(
   input  wire                                clk_i,
   input  wire                                arst_n_i,

   // master
   input  wire                                m_valid_i,
   input  wire  [`SOC_ADDR_W-1:0]             m_addr_i,
   input  wire  [`SOC_DATA_W-1:0]             m_wdata_i,
   input  wire  [`SOC_STRB_W-1:0]             m_wstrb_i,
   output logic                               m_ready_o,
   output logic [`SOC_DATA_W-1:0]             m_rdata_o,
   output logic                               m_rvalid_o,

   // slaves, index 0 is the internal memory
   output logic [1:0]                         s_valid_o,
   output logic [1:0][`SOC_ADDR_W-1:0]        s_addr_o,
   output logic [1:0][`SOC_DATA_W-1:0]        s_wdata_o,
   output logic [1:0][`SOC_STRB_W-1:0]        s_wstrb_o,
   input  wire  [1:0]                         s_ready_i,
   input  wire  [1:0][`SOC_DATA_W-1:0]        s_rdata_i,
   input  wire  [1:0]                         s_rvalid_i
);

   soc_addr_t m_addr;
   logic      sel;
   logic      rd_acc;
   logic      rd_pend_q;
   logic      rd_sel_q;

   assign m_addr.raw = m_addr_i;
   assign sel        = m_addr.mem.sel;

   // request path is purely combinational
   always_comb begin
      for (int s = 0; s < 2; s++) begin
         s_valid_o[s] = m_valid_i && (sel == 1'(s));
         s_addr_o[s]  = m_addr_i;
         s_wdata_o[s] = m_wdata_i;
         s_wstrb_o[s] = m_wstrb_i;
      end
   end

   assign m_ready_o = s_ready_i[sel];

   assign rd_acc = m_valid_i && m_ready_o && (m_wstrb_i == '0);

   // remember who owes the next read response
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_pend_q <= 1'b0;
         rd_sel_q  <= 1'b0;
      end else begin
         rd_pend_q <= rd_acc;
         if (rd_acc) begin
            rd_sel_q <= sel;
         end
      end
   end

   assign m_rvalid_o = rd_pend_q && s_rvalid_i[rd_sel_q];
   assign m_rdata_o  = s_rdata_i[rd_sel_q];

   // slaves never answer in the same cycle
   a_one_rvalid : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      !(s_rvalid_i[0] && s_rvalid_i[1])
   );

   // an accepted read is always answered by the slave it went to
   a_resp_due : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      rd_pend_q |-> s_rvalid_i[rd_sel_q]
   );

endmodule

`default_nettype wire

/* src/soc_pkg.sv */
`default_nettype none

package soc_pkg;

`include "soc_config.svh"

   // timer register map
   typedef enum logic [1:0] {
      TMR_COUNT  = 2'd0,
      TMR_CTRL   = 2'd1,
      TMR_CMP    = 2'd2,
      TMR_STATUS = 2'd3
   } timer_reg_e;

   // internal memory view of an address
   typedef struct packed {
      logic                                sel;
      logic                                ctrl;
      logic [`SOC_ADDR_W-`SOC_SRAM_AW-5:0] rsvd;
      logic [`SOC_SRAM_AW-1:0]             word;
      logic [1:0]                          byte_off;
   } soc_mem_addr_t;

   // peripheral view, register index right above the byte bits
   typedef struct packed {
      logic                   sel;
      logic [`SOC_ADDR_W-6:0] rsvd;
      timer_reg_e             reg_idx;
      logic [1:0]             byte_off;
   } soc_periph_addr_t;

   typedef union packed {
      logic [`SOC_ADDR_W-1:0] raw;
      soc_mem_addr_t          mem;
      soc_periph_addr_t       periph;
   } soc_addr_t;

endpackage

`default_nettype wire

/* include/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// bus widths, one word each
`define SOC_ADDR_W 16
`define SOC_DATA_W 32

// byte strobes per data word
`define SOC_STRB_W (`SOC_DATA_W / 8)

// slave select, 0 internal memory, 1 timer
`define SOC_SEL_BIT 15

// boot control register instead of sram
`define SOC_CTRL_BIT 14

// word address widths
`define SOC_SRAM_AW 10
`define SOC_ROM_AW 8

// cpu reset pulse length in cycles
`define SOC_RST_CYCLES 4

`endif
